/* sram_macros.svh */
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// axi-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// word index width, 256 words
`define SRAM_IDX_W 8
`define SRAM_DEPTH (1 << `SRAM_IDX_W)

// core boots from the start of the array
`define CPU_RESET_ADDR 32'h80000000
`define SRAM_BASE `CPU_RESET_ADDR

// addi x0, x0, 0
`define INST_NOP 32'h00000013

// modeled latency range is 1 to WAIT_MAX cycles
`define WAIT_MAX 8
// any nonzero start value for the latency lfsr
`define LFSR_SEED 8'h5a

`endif

/* axi_lite_pkg.sv */
`include "sram_macros.svh"

package axi_lite_pkg;

    // address and data words
    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] data_t;

    // byte strobe for the W channel
    typedef logic [`AXI_STRB_W-1:0] strb_t;

    // response code on R and B
    typedef logic [1:0] resp_t;

    // only the two codes this slave returns
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // R channel payload
    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_payload_t;

    // B channel payload
    typedef struct packed {
        resp_t resp;
    } b_payload_t;

endpackage

/* sram_pkg.sv */
`include "sram_macros.svh"

package sram_pkg;

    // control fsm states
    // idle    -> waits for AR or AW+W
    // addr    -> latched request, range decode
    // wait    -> modeled sram latency
    // resp    -> response held for the master
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        WAIT = 2'b10,
        RESP = 2'b11
    } ctrl_state_t;

    // word index into the array
    typedef logic [`SRAM_IDX_W-1:0] word_idx_t;

endpackage

/* sram_wait_gen.sv */
`timescale 1ns/10ps
`include "sram_macros.svh"

module sram_wait_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic wait_start,
    output logic wait_done
);

    // wide enough to hold WAIT_MAX
    localparam int CNT_W = $clog2(`WAIT_MAX + 1);

    logic [7:0]       lfsr;
    logic             lfsr_fb;
    logic [CNT_W-1:0] pick;
    logic [CNT_W-1:0] cnt;
    logic             running;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // latency for the next access, 1 .. WAIT_MAX
    assign pick = CNT_W'(lfsr % `WAIT_MAX) + CNT_W'(1);

    // last counted cycle
    assign wait_done = running && (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr    <= `LFSR_SEED;
            cnt     <= '0;
            running <= 1'b0;
        end else begin
            // lfsr free-runs so latency depends on request timing too
            lfsr <= {lfsr[6:0], lfsr_fb};
            if (wait_start) begin
                cnt     <= pick;
                running <= 1'b1;
            end else if (running) begin
                cnt <= cnt - CNT_W'(1);
                if (cnt == CNT_W'(1)) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // a running count stays inside the latency window
    assert property (@(posedge clk) disable iff (!rst_n)
        running |-> (cnt != '0) && (cnt <= CNT_W'(`WAIT_MAX)));

    // controller never restarts a count that is still running
    assert property (@(posedge clk) disable iff (!rst_n)
        wait_start |-> !running);

endmodule

/* sram_array.sv */
`timescale 1ns/10ps
`include "sram_macros.svh"

module sram_array
    import axi_lite_pkg::*, sram_pkg::*;
(
    input  logic      clk,
    input  word_idx_t sram_idx,
    input  logic      sram_we,
    input  data_t     sram_wdata,
    input  strb_t     sram_wstrb,
    output data_t     sram_rdata
);

    // storage, one data word per index
    data_t mem [0:`SRAM_DEPTH-1];

    // contents start at zero
    initial begin
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // zero-latency read
    assign sram_rdata = mem[sram_idx];

    // byte-strobed write on the edge
    always_ff @(posedge clk) begin
        if (sram_we) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                // unstrobed bytes keep old value
                if (sram_wstrb[b]) begin
                    mem[sram_idx][8*b +: 8] <= sram_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* axi_resp_hold.sv */
`timescale 1ns/10ps

module axi_resp_hold #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t payload_in,
    input  logic     ready,
    output logic     valid,
    output payload_t payload_out
);

    payload_t payload_q;

    // valid up the cycle after load, down the cycle after handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // payload only captured on load
    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= payload_in;
        end
    end

    assign payload_out = payload_q;

    // stalled response must not change or drop
    assert property (@(posedge clk) disable iff (!rst_n)
        (valid && !ready) |=> (valid && $stable(payload_out)));

    // controller only loads once the previous response is gone
    assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !valid);

endmodule

/* sram_ctrl.sv */
`timescale 1ns/10ps
`include "sram_macros.svh"

module sram_ctrl
    import axi_lite_pkg::*, sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // AR
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    // AW and W, taken together
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,
    // latency generator
    output logic       wait_start,
    input  logic       wait_done,
    // array port
    output word_idx_t  sram_idx,
    output logic       sram_we,
    output data_t      sram_wdata,
    output strb_t      sram_wstrb,
    input  data_t      sram_rdata,
    // response registers
    output logic       r_load,
    output r_payload_t r_payload,
    input  logic       r_busy,
    output logic       b_load,
    output b_payload_t b_payload,
    input  logic       b_busy
);

    // byte span of the array from SRAM_BASE
    localparam addr_t SRAM_BYTES = addr_t'(`SRAM_DEPTH * `AXI_STRB_W);

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic  ar_fire;
    logic  wr_fire;
    logic  access;
    addr_t addr_q;
    addr_t offset;
    data_t wdata_q;
    strb_t wstrb_q;
    logic  is_wr_q;
    logic  in_range_q;

    // reads win ties, AW and W only accepted as a pair
    assign arready = (state == IDLE);
    assign awready = (state == IDLE) && !arvalid && wvalid;
    assign wready  = (state == IDLE) && !arvalid && awvalid;

    assign ar_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ar_fire || wr_fire) begin
                    next_state = ADDR;
                end
            end
            // single decode cycle
            ADDR: next_state = WAIT;
            WAIT: begin
                if (wait_done) begin
                    next_state = RESP;
                end
            end
            // busy drops the cycle after the handshake
            RESP: begin
                if (!(r_busy || b_busy)) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // request latch on the accepting edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q     <= `CPU_RESET_ADDR;
            is_wr_q    <= 1'b0;
            in_range_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                addr_q  <= araddr;
                is_wr_q <= 1'b0;
            end else if (wr_fire) begin
                addr_q  <= awaddr;
                is_wr_q <= 1'b1;
            end
            // addresses below base wrap to a large offset
            if (state == ADDR) begin
                in_range_q <= (offset < SRAM_BYTES);
            end
        end
    end

    // write data and strobe for the pending access
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    assign offset = addr_q - `SRAM_BASE;

    // latency count starts once the request is decoded
    assign wait_start = (state == ADDR);

    // access and response load in the last wait cycle
    assign access = (state == WAIT) && wait_done;

    assign sram_idx   = offset[`SRAM_IDX_W+1:2];
    // out-of-range writes are dropped
    assign sram_we    = access && is_wr_q && in_range_q;
    assign sram_wdata = wdata_q;
    assign sram_wstrb = wstrb_q;

    assign r_load = access && !is_wr_q;
    assign b_load = access && is_wr_q;

    // bad reads return a nop with slverr
    always_comb begin
        r_payload.data = in_range_q ? sram_rdata : `INST_NOP;
        r_payload.resp = in_range_q ? RESP_OKAY : RESP_SLVERR;
        b_payload.resp = in_range_q ? RESP_OKAY : RESP_SLVERR;
    end

    // one transaction in flight, nothing held when a new response loads
    assert property (@(posedge clk) disable iff (!rst_n)
        (r_load || b_load) |-> !(r_busy || b_busy));

    // exactly one response register picks up each load
    assert property (@(posedge clk) disable iff (!rst_n)
        (r_load || b_load) |=> (r_busy != b_busy));

endmodule

/* axi_sram_top.sv */
`timescale 1ns/10ps

module axi_sram_top
    import axi_lite_pkg::*, sram_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // AR
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    // R
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,
    // AW
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    // W
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    // B
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready
);

    logic       wait_start;
    logic       wait_done;
    word_idx_t  sram_idx;
    logic       sram_we;
    data_t      sram_wdata;
    strb_t      sram_wstrb;
    data_t      sram_rdata;
    logic       r_load;
    r_payload_t r_payload;
    r_payload_t r_out;
    logic       b_load;
    b_payload_t b_payload;
    b_payload_t b_out;

    // fsm, request latch, range decode
    sram_ctrl u_sram_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .wait_start (wait_start),
        .wait_done  (wait_done),
        .sram_idx   (sram_idx),
        .sram_we    (sram_we),
        .sram_wdata (sram_wdata),
        .sram_wstrb (sram_wstrb),
        .sram_rdata (sram_rdata),
        .r_load     (r_load),
        .r_payload  (r_payload),
        .r_busy     (rvalid),
        .b_load     (b_load),
        .b_payload  (b_payload),
        .b_busy     (bvalid)
    );

    // pseudo-random sram latency
    sram_wait_gen u_sram_wait_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .wait_start (wait_start),
        .wait_done  (wait_done)
    );

    sram_array u_sram_array (
        .clk        (clk),
        .sram_idx   (sram_idx),
        .sram_we    (sram_we),
        .sram_wdata (sram_wdata),
        .sram_wstrb (sram_wstrb),
        .sram_rdata (sram_rdata)
    );

    // R channel hold
    axi_resp_hold #(.payload_t(r_payload_t)) u_r_hold (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (r_load),
        .payload_in  (r_payload),
        .ready       (rready),
        .valid       (rvalid),
        .payload_out (r_out)
    );

    // B channel hold
    axi_resp_hold #(.payload_t(b_payload_t)) u_b_hold (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (b_load),
        .payload_in  (b_payload),
        .ready       (bready),
        .valid       (bvalid),
        .payload_out (b_out)
    );

    assign rdata = r_out.data;
    assign rresp = r_out.resp;
    assign bresp = b_out.resp;

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // start low, first rising edge at half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* tb_axi_sram.sv */
`timescale 1ns/10ps
`include "sram_macros.svh"

module tb_axi_sram
    import axi_lite_pkg::*;
();

    localparam int TIMEOUT = 100;
    localparam int N_TXN   = 400;

    logic  clk;
    logic  rst_n;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;

    integer seed;
    int     n_done;
    // reference copy of the array contents
    data_t  model [0:`SRAM_DEPTH-1];

    tb_clk_gen #(.PERIOD_NS(40)) u_tb_clk_gen (.clk(clk));

    axi_sram_top u_axi_sram_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_r(input data_t exp_data, input resp_t exp_resp);
        if (rdata !== exp_data) begin
            report_failure($sformatf("Mismatch at %0t: rdata expected %08h got %08h",
                $time, exp_data, rdata));
        end
        if (rresp !== exp_resp) begin
            report_failure($sformatf("Mismatch at %0t: rresp expected %0d got %0d",
                $time, exp_resp, rresp));
        end
    endtask

    task automatic check_b(input resp_t exp_resp);
        if (bresp !== exp_resp) begin
            report_failure($sformatf("Mismatch at %0t: bresp expected %0d got %0d",
                $time, exp_resp, bresp));
        end
    endtask

    // handshake flags
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s expected %b got %b",
                $time, name, exp, got));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // array covers 1 KiB from the base
    function automatic logic addr_in_range(input addr_t a);
        return (a >= `SRAM_BASE) && (a < `SRAM_BASE + `SRAM_DEPTH * 4);
    endfunction

    function automatic logic [`SRAM_IDX_W-1:0] model_index(input addr_t a);
        addr_t word;
        word = (a - `SRAM_BASE) / 4;
        return word[`SRAM_IDX_W-1:0];
    endfunction

    // mostly in range, about one in eight outside
    function automatic addr_t pick_addr();
        addr_t a;
        if (rand_below(8) == 0) begin
            a = addr_t'($random(seed)) & ~addr_t'(3);
            if (addr_in_range(a)) begin
                a = a ^ 32'h4000_0000;
            end
        end else begin
            a = `SRAM_BASE + addr_t'(rand_below(`SRAM_DEPTH) * 4);
        end
        return a;
    endfunction

    // samples are pre-edge values, so a high ready here means the handshake
    task automatic wait_read_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!arready) begin
            n++;
            if (n >= TIMEOUT) begin
                report_failure("Timeout: read address not accepted within 100 cycles");
            end
            @(posedge clk);
        end
        arvalid <= 1'b0;
    endtask

    task automatic wait_write_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!(awready && wready)) begin
            if (awready != wready) begin
                report_failure("Write address and write data not accepted together");
            end
            n++;
            if (n >= TIMEOUT) begin
                report_failure("Timeout: write not accepted within 100 cycles");
            end
            @(posedge clk);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic finish_read(input data_t exp_data, input resp_t exp_resp, input int delay);
        int n;
        n = 0;
        @(posedge clk);
        while (!rvalid) begin
            // a read must never produce a B response
            check_bit("bvalid", bvalid, 1'b0);
            n++;
            if (n >= TIMEOUT) begin
                report_failure("Timeout: no read response within 100 cycles");
            end
            @(posedge clk);
        end
        check_r(exp_data, exp_resp);
        // stalled response must hold its payload
        repeat (delay) begin
            @(posedge clk);
            check_bit("rvalid", rvalid, 1'b1);
            check_r(exp_data, exp_resp);
        end
        rready <= 1'b1;
        @(posedge clk);
        check_bit("rvalid", rvalid, 1'b1);
        check_r(exp_data, exp_resp);
        rready <= 1'b0;
        // only one response per request
        @(posedge clk);
        check_bit("rvalid", rvalid, 1'b0);
    endtask

    task automatic finish_write(input resp_t exp_resp, input int delay);
        int n;
        n = 0;
        @(posedge clk);
        while (!bvalid) begin
            check_bit("rvalid", rvalid, 1'b0);
            n++;
            if (n >= TIMEOUT) begin
                report_failure("Timeout: no write response within 100 cycles");
            end
            @(posedge clk);
        end
        check_b(exp_resp);
        repeat (delay) begin
            @(posedge clk);
            check_bit("bvalid", bvalid, 1'b1);
            check_b(exp_resp);
        end
        bready <= 1'b1;
        @(posedge clk);
        check_bit("bvalid", bvalid, 1'b1);
        check_b(exp_resp);
        bready <= 1'b0;
        @(posedge clk);
        check_bit("bvalid", bvalid, 1'b0);
    endtask

    // expected read result from the model
    task automatic expect_read(input addr_t a, output data_t exp_data, output resp_t exp_resp);
        if (addr_in_range(a)) begin
            exp_data = model[model_index(a)];
            exp_resp = RESP_OKAY;
        end else begin
            exp_data = `INST_NOP;
            exp_resp = RESP_SLVERR;
        end
    endtask

    // strobed bytes only, out-of-range writes dropped
    task automatic apply_write(input addr_t a, input data_t d, input strb_t s);
        if (addr_in_range(a)) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    model[model_index(a)][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
    endtask

    task automatic run_read(input addr_t a, input int delay);
        data_t exp_data;
        resp_t exp_resp;
        expect_read(a, exp_data, exp_resp);
        araddr  <= a;
        arvalid <= 1'b1;
        wait_read_accept();
        finish_read(exp_data, exp_resp, delay);
    endtask

    task automatic run_write(input addr_t a, input data_t d, input strb_t s, input int delay);
        resp_t exp_resp;
        exp_resp = addr_in_range(a) ? RESP_OKAY : RESP_SLVERR;
        awaddr  <= a;
        awvalid <= 1'b1;
        wdata   <= d;
        wstrb   <= s;
        wvalid  <= 1'b1;
        wait_write_accept();
        finish_write(exp_resp, delay);
        apply_write(a, d, s);
    endtask

    // AR, AW and W in the same cycle, read must go first
    task automatic run_tied(input addr_t ra, input addr_t wa, input data_t d, input strb_t s);
        data_t exp_data;
        resp_t exp_resp;
        expect_read(ra, exp_data, exp_resp);
        araddr  <= ra;
        arvalid <= 1'b1;
        awaddr  <= wa;
        awvalid <= 1'b1;
        wdata   <= d;
        wstrb   <= s;
        wvalid  <= 1'b1;
        wait_read_accept();
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
        finish_read(exp_data, exp_resp, 0);
        wait_write_accept();
        finish_write(addr_in_range(wa) ? RESP_OKAY : RESP_SLVERR, 0);
        apply_write(wa, d, s);
    endtask

    initial begin
        addr_t a;
        int    delay;
        seed    = 32'hc5093fac;
        n_done  = 0;
        model   = '{default: '0};
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // idle after reset
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("arready", arready, 1'b1);
        for (int i = 0; i < N_TXN; i++) begin
            a     = pick_addr();
            delay = rand_below(4);
            if (rand_below(2) == 0) begin
                run_read(a, delay);
            end else begin
                run_write(a, data_t'($random(seed)), strb_t'($random(seed)), delay);
            end
            n_done++;
            if (i % 50 == 49) begin
                run_tied(pick_addr(), pick_addr(), data_t'($random(seed)),
                    strb_t'($random(seed)));
                n_done += 2;
            end
        end
        $display("%0d transactions checked", n_done);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
axi_lite_pkg.sv
sram_pkg.sv
sram_wait_gen.sv
sram_array.sv
axi_resp_hold.sv
sram_ctrl.sv
axi_sram_top.sv
tb_clk_gen.sv
tb_axi_sram.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the AXI-lite SRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps -f files.f \
    --top-module tb_axi_sram -o sim_axi_sram > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_axi_sram > sim.log 2>&1 || true
cat sim.log
grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
